// File: rtl/prefetch_cfg_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// prefetch sizing
////////////////////////////////////////////////////////////////////////////

package prefetch_cfg_pkg;

  // instruction address width, byte addressed
  localparam int unsigned addr_w = 32;

  // width of one instruction memory word
  localparam int unsigned word_w = 32;

  // word entries in the fetch buffer
  // must be 3 or more, the aligner looks at entries 0 and 1
  // and the ready flag watches entry depth-2
  localparam int unsigned fifo_depth = 4;

endpackage

`default_nettype wire

// File: rtl/prefetch_types_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// prefetch enumerations
////////////////////////////////////////////////////////////////////////////

package prefetch_types_pkg;

  // memory side four-phase handshake
  typedef enum logic [1:0] {
    // nothing open, next transfer may start
    st_idle    = 2'd0,
    // req high, address stable, waiting for ack
    st_req     = 2'd1,
    // req dropped, waiting for ack to fall
    st_release = 2'd2
  } fetch_state_e;

  // length class of the instruction at the buffer head
  typedef enum logic {
    // low two bits not both one, compressed
    len_16 = 1'b0,
    len_32 = 1'b1
  } instr_len_e;

endpackage

`default_nettype wire

// File: rtl/fetch_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_fifo (
  input  logic                                clk,
  input  logic                                rst_n,

  // drop everything, takes effect next cycle
  input  logic                                clear_i,

  // word side from the fetch controller
  input  logic                                in_valid_i,
  input  logic [prefetch_cfg_pkg::addr_w-1:0] in_addr_i,
  input  logic [prefetch_cfg_pkg::word_w-1:0] in_rdata_i,
  output logic                                in_ready_o,

  // instruction side towards the decoder
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic [prefetch_cfg_pkg::word_w-1:0] out_rdata_o,
  output logic [prefetch_cfg_pkg::addr_w-1:0] out_addr_o,
  output logic                                out_compressed_o
);

  import prefetch_cfg_pkg::*;
  import prefetch_types_pkg::*;

  // entry 0 is the head, it holds the word containing out_addr_o
  logic [word_w-1:0]     rdata_q   [fifo_depth];
  logic [word_w-1:0]     rdata_int [fifo_depth];
  logic [word_w-1:0]     rdata_n   [fifo_depth];
  logic [fifo_depth-1:0] valid_q;
  logic [fifo_depth-1:0] valid_int;
  logic [fifo_depth-1:0] valid_n;

  // halfword address of the head instruction
  logic [addr_w-1:0]     addr_q;
  logic [addr_w-1:0]     addr_int;
  logic [addr_w-1:0]     addr_n;
  logic [addr_w-1:0]     word_next;

  // aligner inputs
  logic [word_w-1:0]     head_rdata;
  logic [word_w-1:0]     next_rdata;
  logic                  head_valid;
  logic                  next_valid;
  logic [15:0]           head_half;
  instr_len_e            head_len;

  logic                  pop;
  logic                  shift;
  logic                  placed;

  // length class of a halfword as seen by the decoder
  function automatic instr_len_e len_decode(input logic [15:0] half);
    instr_len_e len;
    if (half[1:0] == 2'b11) begin
      len = len_32;
    end else begin
      len = len_16;
    end
    return len;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // aligner
  ////////////////////////////////////////////////////////////////////////////

  // an empty buffer forwards the incoming word straight through
  assign head_rdata = valid_q[0] ? rdata_q[0] : in_rdata_i;
  assign head_valid = valid_q[0] | in_valid_i;

  // second word for instructions crossing into the next word
  assign next_rdata = valid_q[1] ? rdata_q[1] : in_rdata_i;
  // entry 1 stored, or entry 0 stored and its follower arriving now
  assign next_valid = valid_q[1] | (valid_q[0] & in_valid_i);

  assign out_addr_o = valid_q[0] ? addr_q : in_addr_i;

  always_comb begin
    // upper half of the head word when the address sits on bit 1
    head_half = out_addr_o[1] ? head_rdata[31:16] : head_rdata[15:0];
    head_len  = len_decode(head_half);

    if (out_addr_o[1]) begin
      // unaligned, the high half of the head is the low half of the instruction
      out_rdata_o = {next_rdata[15:0], head_rdata[31:16]};
      if (head_len == len_16) begin
        out_valid_o = head_valid;
      end else begin
        // upper half lives in the next word
        out_valid_o = next_valid;
      end
    end else begin
      out_rdata_o = head_rdata;
      out_valid_o = head_valid;
    end
  end

  assign out_compressed_o = (head_len == len_16);

  ////////////////////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////////////////////

  // keep room for the one transfer the controller may still have open
  assign in_ready_o = ~valid_q[fifo_depth-2];

  // insert the incoming word into the first free entry
  // entries fill from 0 upwards without holes
  always_comb begin
    rdata_int = rdata_q;
    valid_int = valid_q;
    placed    = 1'b0;

    if (in_valid_i) begin
      for (int i = 0; i < fifo_depth; i++) begin
        if (!valid_q[i] && !placed) begin
          rdata_int[i] = in_rdata_i;
          valid_int[i] = 1'b1;
          placed       = 1'b1;
        end
      end
    end
  end

  // address tracks the incoming word while the buffer is empty
  assign addr_int  = out_addr_o;
  assign word_next = {addr_int[addr_w-1:2], 2'b00} + addr_w'(4);

  ////////////////////////////////////////////////////////////////////////////
  // consume and shift
  ////////////////////////////////////////////////////////////////////////////

  assign pop = out_valid_o & out_ready_i;

  // head word is used up unless an aligned 16-bit one leaves its high half
  assign shift = out_addr_o[1] | (head_len == len_32);

  always_comb begin
    rdata_n = rdata_int;
    valid_n = valid_int;
    addr_n  = addr_int;

    if (pop) begin
      if (shift) begin
        // only an unaligned 32-bit instruction leaves us on bit 1 again
        addr_n = {word_next[addr_w-1:2], out_addr_o[1] & (head_len == len_32), 1'b0};
        for (int i = 0; i < fifo_depth - 1; i++) begin
          rdata_n[i] = rdata_int[i+1];
        end
        valid_n = {1'b0, valid_int[fifo_depth-1:1]};
      end else begin
        // stay in the same word, move to its high half
        addr_n = {addr_int[addr_w-1:2], 2'b10};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      // branch, start from an empty buffer
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  // payload, qualified by valid_q
  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
    addr_q  <= addr_n;
  end

endmodule

`default_nettype wire

// File: rtl/fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,

  // redirect from the core, one cycle pulse
  input  logic                                branch_i,
  input  logic [prefetch_cfg_pkg::addr_w-1:0] branch_addr_i,

  // instruction memory, four-phase req/ack
  output logic                                mem_req_o,
  output logic [prefetch_cfg_pkg::addr_w-1:0] mem_addr_o,
  input  logic                                mem_ack_i,
  input  logic [prefetch_cfg_pkg::word_w-1:0] mem_rdata_i,

  // word push into the fetch buffer
  output logic                                buf_valid_o,
  output logic [prefetch_cfg_pkg::addr_w-1:0] buf_addr_o,
  output logic [prefetch_cfg_pkg::word_w-1:0] buf_rdata_o,
  input  logic                                buf_ready_i,
  output logic                                buf_clear_o
);

  import prefetch_cfg_pkg::*;
  import prefetch_types_pkg::*;

  fetch_state_e      state_q;
  fetch_state_e      state_d;

  // word address of the next transfer to start
  logic [addr_w-1:0] next_addr_q;
  // address of the open transfer, held while req is high
  logic [addr_w-1:0] mem_addr_q;

  // open transfer belongs to the old path
  logic              discard_q;
  // next delivered word is the first one after a redirect
  logic              first_q;
  logic              first_bit1_q;

  logic [addr_w-1:0] target_word;
  logic [addr_w-1:0] start_addr;
  logic              start;
  logic              accept;
  logic              take;

  assign target_word = {branch_addr_i[addr_w-1:2], 2'b00};

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  // a redirect empties the buffer, so it may start a transfer on its own
  assign start      = (state_q == st_idle) & (branch_i | buf_ready_i);
  assign start_addr = branch_i ? target_word : next_addr_q;

  // data is sampled on the first cycle ack is seen high
  assign accept = (state_q == st_req) & mem_ack_i;
  // words from the old path never reach the buffer
  assign take   = accept & ~discard_q & ~branch_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (start) begin
          state_d = st_req;
        end
      end
      st_req: begin
        if (mem_ack_i) begin
          state_d = st_release;
        end
      end
      st_release: begin
        // req may rise again only after ack was seen low
        if (!mem_ack_i) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  assign mem_req_o  = (state_q == st_req);
  assign mem_addr_o = mem_addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // buffer side
  ////////////////////////////////////////////////////////////////////////////

  assign buf_valid_o = take;
  assign buf_rdata_o = mem_rdata_i;
  // first word after a redirect carries the target halfword
  assign buf_addr_o  = {mem_addr_q[addr_w-1:2], first_q & first_bit1_q, 1'b0};
  assign buf_clear_o = branch_i;

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= st_idle;
      next_addr_q <= '0;
      discard_q   <= 1'b0;
      first_q     <= 1'b0;
    end else begin
      state_q <= state_d;

      // redirect wins over the word advance
      if (branch_i) begin
        next_addr_q <= target_word;
      end else if (take) begin
        next_addr_q <= mem_addr_q + addr_w'(4);
      end

      // a transfer still waiting for ack finishes, its word is dropped
      if (branch_i && (state_q == st_req) && !mem_ack_i) begin
        discard_q <= 1'b1;
      end else if (accept) begin
        discard_q <= 1'b0;
      end

      if (branch_i) begin
        first_q <= 1'b1;
      end else if (take) begin
        first_q <= 1'b0;
      end
    end
  end

  // payload, only looked at while req is high or first_q is set
  always_ff @(posedge clk) begin
    if (start) begin
      mem_addr_q <= start_addr;
    end
    if (branch_i) begin
      first_bit1_q <= branch_addr_i[1];
    end
  end

endmodule

`default_nettype wire

// File: rtl/prefetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module prefetch_top (
  input  logic                                clk,
  input  logic                                rst_n,

  // redirect
  input  logic                                branch_i,
  input  logic [prefetch_cfg_pkg::addr_w-1:0] branch_addr_i,

  // instruction memory
  output logic                                mem_req_o,
  output logic [prefetch_cfg_pkg::addr_w-1:0] mem_addr_o,
  input  logic                                mem_ack_i,
  input  logic [prefetch_cfg_pkg::word_w-1:0] mem_rdata_i,

  // decoder
  output logic                                instr_valid_o,
  input  logic                                instr_ready_i,
  output logic [prefetch_cfg_pkg::word_w-1:0] instr_rdata_o,
  output logic [prefetch_cfg_pkg::addr_w-1:0] instr_addr_o,
  output logic                                instr_compressed_o
);

  import prefetch_cfg_pkg::*;

  // controller to buffer
  logic              buf_valid;
  logic [addr_w-1:0] buf_addr;
  logic [word_w-1:0] buf_rdata;
  logic              buf_ready;
  logic              buf_clear;

  fetch_ctrl i_fetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i),
    .buf_valid_o   (buf_valid),
    .buf_addr_o    (buf_addr),
    .buf_rdata_o   (buf_rdata),
    .buf_ready_i   (buf_ready),
    .buf_clear_o   (buf_clear)
  );

  // realigns words into one instruction per cycle
  fetch_fifo i_fetch_fifo (
    .clk              (clk),
    .rst_n            (rst_n),
    .clear_i          (buf_clear),
    .in_valid_i       (buf_valid),
    .in_addr_i        (buf_addr),
    .in_rdata_i       (buf_rdata),
    .in_ready_o       (buf_ready),
    .out_valid_o      (instr_valid_o),
    .out_ready_i      (instr_ready_i),
    .out_rdata_o      (instr_rdata_o),
    .out_addr_o       (instr_addr_o),
    .out_compressed_o (instr_compressed_o)
  );

endmodule

`default_nettype wire

// File: testbench/prefetch_assert.sv
`timescale 1ns/100ps
`default_nettype none

module prefetch_assert (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                mem_req_i,
  input logic                                mem_ack_i,
  input logic                                buf_valid_i,
  input logic                                buf_ready_i,
  input logic                                buf_clear_i,
  input logic                                instr_valid_i,
  input logic                                instr_ready_i,
  input logic [prefetch_cfg_pkg::word_w-1:0] instr_rdata_i,
  input logic [prefetch_cfg_pkg::addr_w-1:0] instr_addr_i,
  input logic                                instr_compressed_i
);

  ////////////////////////////////////////////////////////////////////////////
  // four-phase memory handshake
  ////////////////////////////////////////////////////////////////////////////

  // req stays up until the memory answers
  req_held_a : assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i && !mem_ack_i |=> mem_req_i)
    else $error("mem_req dropped before mem_ack");

  // a new request waits for ack to fall
  // ack still high with req low keeps req low on the next edge
  req_rise_a : assert property (@(posedge clk) disable iff (!rst_n)
    !mem_req_i && mem_ack_i |=> !mem_req_i)
    else $error("mem_req rose while mem_ack was high");

  ////////////////////////////////////////////////////////////////////////////
  // buffer fill and decoder side
  ////////////////////////////////////////////////////////////////////////////

  // a returning word always finds a free entry
  buf_room_a : assert property (@(posedge clk) disable iff (!rst_n)
    buf_valid_i && !buf_clear_i |-> buf_ready_i)
    else $error("word pushed into a full fetch buffer");

  // stalled instruction keeps address, length and its defined data bits
  stall_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_i && !instr_ready_i && !buf_clear_i |=>
      instr_valid_i && $stable(instr_addr_i) && $stable(instr_compressed_i) &&
      $stable(instr_rdata_i[15:0]) && (instr_compressed_i || $stable(instr_rdata_i)))
    else $error("instruction output changed under back-pressure");

endmodule

// memory handshake, buffer fill and decoder port of the prefetcher
bind prefetch_top prefetch_assert i_prefetch_assert (
  .clk                (clk),
  .rst_n              (rst_n),
  .mem_req_i          (mem_req_o),
  .mem_ack_i          (mem_ack_i),
  .buf_valid_i        (buf_valid),
  .buf_ready_i        (buf_ready),
  .buf_clear_i        (buf_clear),
  .instr_valid_i      (instr_valid_o),
  .instr_ready_i      (instr_ready_i),
  .instr_rdata_i      (instr_rdata_o),
  .instr_addr_i       (instr_addr_o),
  .instr_compressed_i (instr_compressed_o)
);

`default_nettype wire

// File: testbench/tb_prefetch.sv
`timescale 1ns/100ps
`default_nettype none

module tb_prefetch;

  import prefetch_cfg_pkg::*;

  localparam int n_tests    = 5;
  // program memory in words, addresses wrap inside it
  localparam int prog_words = 64;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              branch;
  logic [addr_w-1:0] branch_addr;
  logic              mem_req;
  logic [addr_w-1:0] mem_addr;
  logic              mem_ack;
  logic [word_w-1:0] mem_rdata;
  logic              instr_valid;
  logic              instr_ready;
  logic [word_w-1:0] instr_rdata;
  logic [addr_w-1:0] instr_addr;
  logic              instr_compressed;

  int seed         = 44148;
  int total_errors = 0;
  int total_instrs = 0;
  int test_errors;

  logic [word_w-1:0] prog [prog_words];

  // test table, one row per test
  string             test_name      [n_tests];
  logic [addr_w-1:0] test_start     [n_tests];
  int                test_count     [n_tests];
  bit                test_rand      [n_tests];
  int                test_br_idx    [n_tests];
  logic [addr_w-1:0] test_br_target [n_tests];

  // expected stream from the reference walker
  logic [addr_w-1:0] exp_addr_q [$];
  logic [word_w-1:0] exp_data_q [$];
  bit                exp_comp_q [$];

  prefetch_top uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .branch_i           (branch),
    .branch_addr_i      (branch_addr),
    .mem_req_o          (mem_req),
    .mem_addr_o         (mem_addr),
    .mem_ack_i          (mem_ack),
    .mem_rdata_i        (mem_rdata),
    .instr_valid_o      (instr_valid),
    .instr_ready_i      (instr_ready),
    .instr_rdata_o      (instr_rdata),
    .instr_addr_o       (instr_addr),
    .instr_compressed_o (instr_compressed)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // program image and reference walker
  ////////////////////////////////////////////////////////////////////////////

  // hashed from the word index, low bits forced to mix the two lengths
  function automatic logic [word_w-1:0] fill_word(input int unsigned i);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = 16'(i * 32'hA5C3 + 32'h3C96);
    hi = 16'((i * 32'h4F1B) ^ 32'h96E5);
    // first 16 words hold only aligned 32-bit instructions
    if (i < 16 || i % 3 == 1) begin
      lo[1:0] = 2'b11;
    end
    // odd words start a 32-bit instruction in their high half
    if (i % 2 == 1) begin
      hi[1:0] = 2'b11;
    end
    return {hi, lo};
  endfunction

  function automatic logic [15:0] half_at(input logic [addr_w-1:0] a);
    logic [word_w-1:0] w;
    w = prog[(a >> 2) % prog_words];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic walk(input logic [addr_w-1:0] from, input int n);
    logic [addr_w-1:0] a;
    logic [15:0]       lo;
    logic [15:0]       hi;
    a = from;
    repeat (n) begin
      lo = half_at(a);
      exp_addr_q.push_back(a);
      if (lo[1:0] != 2'b11) begin
        // compressed, upper half undefined
        exp_data_q.push_back({16'h0000, lo});
        exp_comp_q.push_back(1'b1);
        a = a + 2;
      end else begin
        hi = half_at(a + 2);
        exp_data_q.push_back({hi, lo});
        exp_comp_q.push_back(1'b0);
        a = a + 4;
      end
    end
  endtask

  task automatic set_test(input int t, input string name, input logic [addr_w-1:0] start,
                          input int count, input bit rand_ready, input int br_idx,
                          input logic [addr_w-1:0] br_target);
    test_name[t]      = name;
    test_start[t]     = start;
    test_count[t]     = count;
    test_rand[t]      = rand_ready;
    test_br_idx[t]    = br_idx;
    test_br_target[t] = br_target;
  endtask

  task automatic load_table();
    set_test(0, "aligned_32", 32'h0000_0000, 12, 1'b0, -1, '0);
    set_test(1, "mixed_16_32", 32'h0000_0040, 40, 1'b0, -1, '0);
    // odd halfword target in word 49, a 32-bit one across two words
    set_test(2, "branch_odd_half", 32'h0000_0080, 30, 1'b0, 5, 32'h0000_00c6);
    set_test(3, "branch_open_xfer", 32'h0000_0040, 30, 1'b0, 9, 32'h0000_0012);
    set_test(4, "random_stall", 32'h0000_0020, 60, 1'b1, 30, 32'h0000_00a2);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction memory, four-phase with random ack delay
  ////////////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    int delay;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      #2;
      if (mem_req && !mem_ack) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
          @(posedge clk);
          #2;
        end
        mem_ack   = 1'b1;
        mem_rdata = prog[(mem_addr >> 2) % prog_words];
      end else if (!mem_req && mem_ack) begin
        // data only valid while ack is high
        mem_ack   = 1'b0;
        mem_rdata = 'x;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks and test sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_instr(input int t, input int idx);
    logic [word_w-1:0] mask;
    mask = exp_comp_q[idx] ? word_w'(16'hffff) : '1;
    if (instr_addr !== exp_addr_q[idx]) begin
      $display("CHECK FAILED %s instr %0d address: expected %h actual %h",
               test_name[t], idx, exp_addr_q[idx], instr_addr);
      test_errors++;
    end
    if ((instr_rdata & mask) !== (exp_data_q[idx] & mask)) begin
      $display("CHECK FAILED %s instr %0d data: expected %h actual %h",
               test_name[t], idx, exp_data_q[idx] & mask, instr_rdata & mask);
      test_errors++;
    end
    if (instr_compressed !== exp_comp_q[idx]) begin
      $display("CHECK FAILED %s instr %0d compressed: expected %b actual %b",
               test_name[t], idx, exp_comp_q[idx], instr_compressed);
      test_errors++;
    end
  endtask

  task automatic run_test(input int t);
    int got;
    int hold;
    bit branched;
    bit next_ready;
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_comp_q.delete();
    if (test_br_idx[t] >= 0) begin
      walk(test_start[t], test_br_idx[t]);
      walk(test_br_target[t], test_count[t] - test_br_idx[t]);
    end else begin
      walk(test_start[t], test_count[t]);
    end
    got         = 0;
    hold        = 0;
    test_errors = 0;
    branched    = (test_br_idx[t] < 0);
    next_ready  = 1'b1;
    // redirect to the test start, whatever is buffered gets dropped
    @(posedge clk);
    #2;
    instr_ready = 1'b0;
    branch      = 1'b1;
    branch_addr = test_start[t];
    @(posedge clk);
    #2;
    while (got < test_count[t]) begin
      if (!branched && got == test_br_idx[t]) begin
        // stall the decoder, then redirect while a request is open
        branch      = 1'b0;
        instr_ready = 1'b0;
        hold++;
        if (mem_req || hold > 4) begin
          branch      = 1'b1;
          branch_addr = test_br_target[t];
          branched    = 1'b1;
        end
      end else begin
        branch      = 1'b0;
        instr_ready = next_ready;
      end
      @(negedge clk);
      if (instr_valid && instr_ready) begin
        check_instr(t, got);
        got++;
      end
      next_ready = test_rand[t] ? (($random(seed) & 3) != 0) : 1'b1;
      @(posedge clk);
      #2;
    end
    branch      = 1'b0;
    instr_ready = 1'b0;
    total_instrs += got;
    total_errors += test_errors;
    $display("test %s: %0d instructions, %0d mismatches, %s",
             test_name[t], got, test_errors, (test_errors == 0) ? "ok" : "FAILED");
  endtask

  initial begin : main
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    instr_ready = 1'b0;
    load_table();
    for (int i = 0; i < prog_words; i++) begin
      prog[i] = fill_word(i);
    end
    repeat (10) @(posedge clk);
    #2;
    // nothing leaves the prefetcher while reset is held
    if (mem_req !== 1'b0 || instr_valid !== 1'b0) begin
      $display("reset: mem_req or instr_valid is not low during reset");
      total_errors++;
    end
    rst_n = 1'b1;
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d instructions checked, %0d errors",
             n_tests, total_instrs, total_errors);
    if (total_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // limit scales with the instruction count of the table
  initial begin : watchdog
    int limit;
    #1;
    limit = 10;
    for (int t = 0; t < n_tests; t++) begin
      limit += test_count[t] * 40;
    end
    repeat (limit) @(posedge clk);
    $display("run timed out after %0d cycles, an instruction never arrived", limit);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/prefetch_cfg_pkg.sv
rtl/prefetch_types_pkg.sv
rtl/fetch_fifo.sv
rtl/fetch_ctrl.sv
rtl/prefetch_top.sv
testbench/prefetch_assert.sv
testbench/tb_prefetch.sv

// File: Bender.yml
package:
  name: prefetch

sources:
  # packages first, then the design bottom up
  - rtl/prefetch_cfg_pkg.sv
  - rtl/prefetch_types_pkg.sv
  - rtl/fetch_fifo.sv
  - rtl/fetch_ctrl.sv
  - rtl/prefetch_top.sv
  - target: test
    files:
      - testbench/prefetch_assert.sv
      - testbench/tb_prefetch.sv
